//--- verilog/cpu6502_pkg.sv
// ------------------------------------------------------------
// Shared types for the reduced 6502 core
// Opcode values follow the standard 6502 encodings
// Status keeps only the carry flag; N, Z and V are not modelled
// ------------------------------------------------------------
`default_nettype none

package cpu6502_pkg;

  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;

  // Kept opcodes
  typedef enum logic [7:0] {
    lda_imm = 8'hA9,
    ldx_imm = 8'hA2,
    ldy_imm = 8'hA0,
    lda_abs = 8'hAD,
    ldx_abs = 8'hAE,
    ldy_abs = 8'hAC,
    sta_abs = 8'h8D,
    stx_abs = 8'h8E,
    sty_abs = 8'h8C,
    jmp_abs = 8'h4C,
    adc_abs = 8'h6D,
    sbc_abs = 8'hED,
    and_abs = 8'h2D,
    ora_abs = 8'h0D,
    eor_abs = 8'h4D,
    clc_imp = 8'h18,
    sec_imp = 8'h38,
    nop_imp = 8'hEA,
    asl_acc = 8'h0A,
    lsr_acc = 8'h4A,
    rol_acc = 8'h2A,
    ror_acc = 8'h6A
  } opcode_e;

  typedef enum logic [2:0] {
    st_vector_lo,
    st_vector_hi,
    st_fetch,
    st_decode,
    st_abs_lo,
    st_abs_hi,
    st_abs_exec
  } state_e;

  typedef enum logic [1:0] {
    mode_single,
    mode_imm,
    mode_abs,
    mode_jmp
  } addr_mode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_and,
    alu_or,
    alu_xor,
    alu_shl,
    alu_shr
  } alu_op_e;

  typedef enum logic [1:0] {
    dest_none,
    dest_a,
    dest_x,
    dest_y
  } dest_e;

  // Execution controls produced by the decoder
  typedef struct packed {
    addr_mode_e mode;
    alu_op_e    alu_op;
    dest_e      dest;
    dest_e      store_src;
    logic       use_alu;
    logic       invert_b;
    logic       carry_en;
    logic       write_carry;
    logic       set_carry_op;
    logic       set_carry_val;
  } decode_t;

  // Byte-wide memory port request
  typedef struct packed {
    word_t address;
    byte_t wr_data;
    logic  wr_enable;
  } bus_req_t;

endpackage

`default_nettype wire

//--- verilog/cpu_alu.sv
// ------------------------------------------------------------
// 8-bit combinational ALU
// Shifts move cin into the vacated bit and the lost bit to cout
// Logic functions pass cin straight through to cout
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
  import cpu6502_pkg::*;
(
  input  wire alu_op_e op,
  input  wire byte_t   a,
  input  wire byte_t   b,
  input  wire logic    cin,
  output byte_t        y,
  output logic         cout
);

  // Nine-bit sum keeps the carry out of bit 7
  logic [8:0] sum;

  assign sum = {1'b0, a} + {1'b0, b} + {8'd0, cin};

  always_comb begin
    y    = a;
    cout = cin;
    case (op)
      alu_add: begin
        y    = sum[7:0];
        cout = sum[8];
      end
      alu_and: begin
        y = a & b;
      end
      alu_or: begin
        y = a | b;
      end
      alu_xor: begin
        y = a ^ b;
      end
      // ASL with cin 0, ROL with the carry flag
      alu_shl: begin
        y    = {a[6:0], cin};
        cout = a[7];
      end
      // LSR with cin 0, ROR with the carry flag
      alu_shr: begin
        y    = {cin, a[7:1]};
        cout = a[0];
      end
      default: begin
        y    = a;
        cout = cin;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cpu_decoder.sv
// ------------------------------------------------------------
// Opcode decoder, purely combinational
// Any opcode outside the kept set decodes as a one-byte NOP
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu_decoder
  import cpu6502_pkg::*;
(
  input  wire opcode_e ir,
  output decode_t      dec
);

  always_comb begin
    // Defaults describe a single-byte instruction with no effect
    dec               = '0;
    dec.mode          = mode_single;
    dec.alu_op        = alu_add;
    dec.dest          = dest_none;
    dec.store_src     = dest_none;

    case (ir)
      // Immediate loads
      lda_imm: begin
        dec.mode = mode_imm;
        dec.dest = dest_a;
      end
      ldx_imm: begin
        dec.mode = mode_imm;
        dec.dest = dest_x;
      end
      ldy_imm: begin
        dec.mode = mode_imm;
        dec.dest = dest_y;
      end

      // Absolute loads and stores
      lda_abs: begin
        dec.mode = mode_abs;
        dec.dest = dest_a;
      end
      ldx_abs: begin
        dec.mode = mode_abs;
        dec.dest = dest_x;
      end
      ldy_abs: begin
        dec.mode = mode_abs;
        dec.dest = dest_y;
      end
      sta_abs: begin
        dec.mode      = mode_abs;
        dec.store_src = dest_a;
      end
      stx_abs: begin
        dec.mode      = mode_abs;
        dec.store_src = dest_x;
      end
      sty_abs: begin
        dec.mode      = mode_abs;
        dec.store_src = dest_y;
      end

      jmp_abs: dec.mode = mode_jmp;

      // ------------------------------------------------------------
      // Accumulator arithmetic and logic, operand from memory
      // ------------------------------------------------------------
      adc_abs, sbc_abs: begin
        dec.mode        = mode_abs;
        dec.alu_op      = alu_add;
        dec.dest        = dest_a;
        dec.use_alu     = 1'b1;
        dec.carry_en    = 1'b1;
        dec.write_carry = 1'b1;
        // A + ~M + C gives the 6502 borrow convention
        dec.invert_b    = (ir == sbc_abs);
      end
      and_abs, ora_abs, eor_abs: begin
        dec.mode    = mode_abs;
        dec.dest    = dest_a;
        dec.use_alu = 1'b1;
        dec.alu_op  = (ir == and_abs) ? alu_and :
                      (ir == ora_abs) ? alu_or : alu_xor;
      end

      // Accumulator shifts and rotates
      asl_acc, lsr_acc, rol_acc, ror_acc: begin
        dec.mode        = mode_single;
        dec.dest        = dest_a;
        dec.use_alu     = 1'b1;
        dec.write_carry = 1'b1;
        dec.alu_op      = (ir == asl_acc || ir == rol_acc) ? alu_shl : alu_shr;
        dec.carry_en    = (ir == rol_acc || ir == ror_acc);
      end

      // Carry flag control
      clc_imp: dec.set_carry_op = 1'b1;
      sec_imp: begin
        dec.set_carry_op  = 1'b1;
        dec.set_carry_val = 1'b1;
      end

      default: dec.mode = mode_single;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cpu_control.sv
// ------------------------------------------------------------
// Control FSM, program counter and memory port
// Memory must answer reads combinationally in the same cycle
// Stores hold wr_enable high for the execute cycle only
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu_control
  import cpu6502_pkg::*;
#(
  parameter word_t reset_vector = 16'hFFFC
) (
  input  wire logic    clk,
  input  wire logic    resetn,
  input  wire byte_t   rd_data,
  input  wire decode_t dec,
  input  wire byte_t   store_data,
  output opcode_e      ir,
  output logic         exec_strobe,
  output bus_req_t     mem_req
);

  state_e state;
  word_t  pc;
  byte_t  operand_lo;
  word_t  addr_q;
  byte_t  wr_data_q;
  logic   wr_en_q;
  logic   is_store;

  assign is_store = (dec.store_src != dest_none);

  // Operand byte is on rd_data in decode for short forms, in exec otherwise
  assign exec_strobe = (state == st_abs_exec) ||
                       ((state == st_decode) &&
                        (dec.mode == mode_single || dec.mode == mode_imm));

  assign mem_req = '{address: addr_q, wr_data: wr_data_q, wr_enable: wr_en_q};

  // ------------------------------------------------------------
  // State, PC and bus address
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state   <= st_vector_lo;
      pc      <= '0;
      ir      <= nop_imp;
      addr_q  <= reset_vector;
      wr_en_q <= 1'b0;
    end else begin
      case (state)
        st_vector_lo: begin
          pc[7:0] <= rd_data;
          addr_q  <= reset_vector + 16'd1;
          state   <= st_vector_hi;
        end
        st_vector_hi: begin
          pc     <= {rd_data, pc[7:0]};
          addr_q <= {rd_data, pc[7:0]};
          state  <= st_fetch;
        end
        st_fetch: begin
          ir     <= opcode_e'(rd_data);
          addr_q <= pc + 16'd1;
          state  <= st_decode;
        end
        st_decode: begin
          case (dec.mode)
            mode_single: begin
              pc     <= pc + 16'd1;
              addr_q <= pc + 16'd1;
              state  <= st_fetch;
            end
            mode_imm: begin
              pc     <= pc + 16'd2;
              addr_q <= pc + 16'd2;
              state  <= st_fetch;
            end
            // Absolute and JMP read the high operand byte next
            default: begin
              addr_q <= pc + 16'd2;
              state  <= st_abs_hi;
            end
          endcase
        end
        st_abs_hi: begin
          addr_q <= {rd_data, operand_lo};
          if (dec.mode == mode_jmp) begin
            pc    <= {rd_data, operand_lo};
            state <= st_fetch;
          end else begin
            wr_en_q <= is_store;
            state   <= st_abs_exec;
          end
        end
        st_abs_exec: begin
          wr_en_q <= 1'b0;
          pc      <= pc + 16'd3;
          addr_q  <= pc + 16'd3;
          state   <= st_fetch;
        end
        default: begin
          wr_en_q <= 1'b0;
          addr_q  <= pc;
          state   <= st_fetch;
        end
      endcase
    end
  end

  // Operand and store data latches
  always_ff @(posedge clk) begin
    if (state == st_decode) begin
      operand_lo <= rd_data;
    end
    if (state == st_abs_hi) begin
      wr_data_q <= store_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_datapath.sv
// ------------------------------------------------------------
// A, X and Y registers plus the carry flag
// Registers load one cycle after exec_strobe
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu_datapath
  import cpu6502_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    resetn,
  input  wire byte_t   rd_data,
  input  wire decode_t dec,
  input  wire logic    exec_strobe,
  input  wire byte_t   alu_y,
  input  wire logic    alu_cout,
  output byte_t        alu_a,
  output byte_t        alu_b,
  output logic         alu_cin,
  output alu_op_e      alu_op,
  output byte_t        store_data
);

  byte_t a_reg;
  byte_t x_reg;
  byte_t y_reg;
  logic  carry_flag;
  byte_t wb_data;
  logic  is_shift;

  // ------------------------------------------------------------
  // ALU operand selection
  // ------------------------------------------------------------
  assign is_shift = (dec.alu_op == alu_shl) || (dec.alu_op == alu_shr);
  assign alu_op   = dec.alu_op;
  assign alu_a    = a_reg;

  always_comb begin
    if (is_shift) begin
      alu_b = a_reg;
    end else if (dec.invert_b) begin
      alu_b = ~rd_data;
    end else begin
      alu_b = rd_data;
    end
  end

  // Shifts without carry_en see a zero coming in
  assign alu_cin = dec.carry_en ? carry_flag : 1'b0;

  // Loads take the memory byte, everything else the ALU result
  assign wb_data = dec.use_alu ? alu_y : rd_data;

  // Source register for STA, STX, STY
  always_comb begin
    case (dec.store_src)
      dest_x:  store_data = x_reg;
      dest_y:  store_data = y_reg;
      default: store_data = a_reg;
    endcase
  end

  // ------------------------------------------------------------
  // Register write-back
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      a_reg      <= '0;
      x_reg      <= '0;
      y_reg      <= '0;
      carry_flag <= 1'b0;
    end else if (exec_strobe) begin
      case (dec.dest)
        dest_a:  a_reg <= wb_data;
        dest_x:  x_reg <= wb_data;
        dest_y:  y_reg <= wb_data;
        default: a_reg <= a_reg;
      endcase

      // CLC and SEC take priority over any ALU carry
      if (dec.set_carry_op) begin
        carry_flag <= dec.set_carry_val;
      end else if (dec.write_carry) begin
        carry_flag <= alu_cout;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu6502_top.sv
// ------------------------------------------------------------
// Reduced 6502 core, single byte-wide memory port
// Read data must be valid in the cycle the address is driven
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cpu6502_top
  import cpu6502_pkg::*;
#(
  parameter word_t reset_vector = 16'hFFFC
) (
  input  wire logic  clk,
  input  wire logic  resetn,
  input  wire byte_t rd_data,
  output bus_req_t   mem_req
);

  opcode_e ir;
  decode_t dec;
  logic    exec_strobe;
  byte_t   store_data;
  byte_t   alu_a;
  byte_t   alu_b;
  byte_t   alu_y;
  logic    alu_cin;
  logic    alu_cout;
  alu_op_e alu_op;

  cpu_control #(
    .reset_vector (reset_vector)
  ) i_control (
    .clk         (clk),
    .resetn      (resetn),
    .rd_data     (rd_data),
    .dec         (dec),
    .store_data  (store_data),
    .ir          (ir),
    .exec_strobe (exec_strobe),
    .mem_req     (mem_req)
  );

  cpu_decoder i_decoder (
    .ir  (ir),
    .dec (dec)
  );

  cpu_datapath i_datapath (
    .clk         (clk),
    .resetn      (resetn),
    .rd_data     (rd_data),
    .dec         (dec),
    .exec_strobe (exec_strobe),
    .alu_y       (alu_y),
    .alu_cout    (alu_cout),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_cin     (alu_cin),
    .alu_op      (alu_op),
    .store_data  (store_data)
  );

  cpu_alu i_alu (
    .op   (alu_op),
    .a    (alu_a),
    .b    (alu_b),
    .cin  (alu_cin),
    .y    (alu_y),
    .cout (alu_cout)
  );

endmodule

`default_nettype wire

//--- verification/tb_memory.sv
// ------------------------------------------------------------
// 64 KiB byte memory model for the core's memory port
// Reads are combinational, bus and load writes are clocked
// Load port wins over a bus write in the same cycle
// Write log holds the last 16 bus writes since reset
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_memory
  import cpu6502_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     resetn,
  input  wire bus_req_t mem_req,
  input  wire logic     load_en,
  input  wire word_t    load_addr,
  input  wire byte_t    load_data,
  output byte_t         rd_data,
  output int            write_count
);

  byte_t mem [0:65535];

  // Bus writes in the order they happened
  word_t wr_addr_log [0:15];
  byte_t wr_data_log [0:15];

  assign rd_data = mem[mem_req.address];

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (mem_req.wr_enable) begin
      mem[mem_req.address] <= mem_req.wr_data;
    end
  end

  // ------------------------------------------------------------
  // Write monitor, cleared while the core is in reset
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      write_count <= 0;
    end else if (mem_req.wr_enable) begin
      wr_addr_log[write_count[3:0]] <= mem_req.address;
      wr_data_log[write_count[3:0]] <= mem_req.wr_data;
      write_count                   <= write_count + 1;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_cpu6502.sv
// ------------------------------------------------------------
// Testbench for the reduced 6502 core
// Each row runs a small program at 0x0400 from a fresh reset
// Results land at 0x0300 and up and the carry is read back through ADC
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_cpu6502
  import cpu6502_pkg::*;
();

  typedef struct packed {
    opcode_e setup;
    byte_t   init_a;
    opcode_e op;
    byte_t   operand;
    byte_t   result;
    logic    carry;
  } row_t;

  localparam int    num_rows  = 18;
  localparam word_t prog_base = 16'h0400;
  // Table rows plus the index register program
  localparam int    timeout_cycles = (num_rows + 1) * 40 + 100;

  // Carry setup, initial A, opcode, operand, result, carry
  localparam row_t test_rows [num_rows] = '{
    '{clc_imp, 8'h12, adc_abs, 8'h34, 8'h46, 1'b0},
    '{sec_imp, 8'h12, adc_abs, 8'h34, 8'h47, 1'b0},
    '{clc_imp, 8'hF0, adc_abs, 8'h20, 8'h10, 1'b1},
    '{sec_imp, 8'hFF, adc_abs, 8'h00, 8'h00, 1'b1},
    '{sec_imp, 8'h50, sbc_abs, 8'h20, 8'h30, 1'b1},
    '{sec_imp, 8'h20, sbc_abs, 8'h50, 8'hD0, 1'b0},
    '{clc_imp, 8'h50, sbc_abs, 8'h20, 8'h2F, 1'b1},
    '{clc_imp, 8'h00, sbc_abs, 8'h00, 8'hFF, 1'b0},
    '{sec_imp, 8'hF0, and_abs, 8'h3C, 8'h30, 1'b1},
    '{clc_imp, 8'hA5, ora_abs, 8'h0F, 8'hAF, 1'b0},
    '{sec_imp, 8'hA5, eor_abs, 8'hFF, 8'h5A, 1'b1},
    '{sec_imp, 8'h81, asl_acc, 8'hFF, 8'h02, 1'b1},
    '{clc_imp, 8'h40, asl_acc, 8'hFF, 8'h80, 1'b0},
    '{sec_imp, 8'h81, lsr_acc, 8'hFF, 8'h40, 1'b1},
    '{sec_imp, 8'h81, rol_acc, 8'hFF, 8'h03, 1'b1},
    '{clc_imp, 8'h40, rol_acc, 8'hFF, 8'h80, 1'b0},
    '{sec_imp, 8'h02, ror_acc, 8'hFF, 8'h81, 1'b0},
    '{clc_imp, 8'h01, ror_acc, 8'hFF, 8'h00, 1'b1}
  };

  logic     clk;
  logic     resetn;
  byte_t    rd_data;
  bus_req_t mem_req;
  logic     load_en;
  word_t    load_addr;
  byte_t    load_data;
  int       write_count;
  int       cycle_count;
  byte_t    prog [$];

  cpu6502_top #(
    .reset_vector (16'hFFFC)
  ) i_dut (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .mem_req (mem_req)
  );

  tb_memory i_mem (
    .clk         (clk),
    .resetn      (resetn),
    .mem_req     (mem_req),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .rd_data     (rd_data),
    .write_count (write_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Only cycles with the core running count toward the limit
  initial begin
    cycle_count = 0;
    while (cycle_count <= timeout_cycles) begin
      @(posedge clk);
      if (resetn) cycle_count++;
    end
    $display("ERROR: timeout, core still running after %0d cycles", timeout_cycles);
    $display("tests failed");
    $fatal(1, "run stopped on timeout");
  end

  // ------------------------------------------------------------
  // Checks and program helpers
  // ------------------------------------------------------------
  task automatic check_value(input word_t got, input word_t exp, input string what);
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "run stopped on first error");
    end
  endtask

  task automatic check_write(input int idx, input word_t addr, input byte_t data,
                             input string what);
    check_value(i_mem.wr_addr_log[idx[3:0]], addr, {what, " address"});
    check_value({8'h00, i_mem.wr_data_log[idx[3:0]]}, {8'h00, data}, {what, " data"});
  endtask

  task automatic emit_imm(input opcode_e op, input byte_t val);
    prog.push_back(op);
    prog.push_back(val);
  endtask

  task automatic emit_abs(input opcode_e op, input word_t addr);
    prog.push_back(op);
    prog.push_back(addr[7:0]);
    prog.push_back(addr[15:8]);
  endtask

  function automatic logic is_single_byte(input opcode_e op);
    return (op == asl_acc) || (op == lsr_acc) || (op == rol_acc) || (op == ror_acc);
  endfunction

  task automatic build_alu_program(input row_t r);
    prog.delete();
    prog.push_back(r.setup);
    emit_imm(lda_imm, r.init_a);
    if (is_single_byte(r.op)) begin
      prog.push_back(r.op);
    end else begin
      emit_abs(r.op, 16'h0200);
    end
    emit_abs(sta_abs, 16'h0300);
    // Carry comes out as 0 + 0 + C
    emit_imm(lda_imm, 8'h00);
    emit_abs(adc_abs, 16'h0201);
    emit_abs(sta_abs, 16'h0301);
    emit_abs(jmp_abs, prog_base + 16'(prog.size()));
  endtask

  task automatic build_index_program();
    prog.delete();
    emit_imm(ldx_imm, 8'h5A);
    emit_imm(ldy_imm, 8'hC3);
    emit_abs(stx_abs, 16'h0300);
    emit_abs(sty_abs, 16'h0301);
    emit_abs(ldx_abs, 16'h0200);
    emit_abs(ldy_abs, 16'h0201);
    emit_abs(stx_abs, 16'h0302);
    emit_abs(sty_abs, 16'h0303);
    emit_abs(jmp_abs, prog_base + 16'(prog.size()));
  endtask

  task automatic load_byte(input word_t addr, input byte_t data);
    @(negedge clk);
    load_en   = 1'b1;
    load_addr = addr;
    load_data = data;
  endtask

  // Load memory under reset, then release and follow the vector read
  task automatic run_program(input byte_t m0, input byte_t m1);
    int i;
    @(negedge clk);
    resetn = 1'b0;
    load_byte(16'hFFFC, prog_base[7:0]);
    load_byte(16'hFFFD, prog_base[15:8]);
    load_byte(16'h0200, m0);
    load_byte(16'h0201, m1);
    for (i = 0; i < prog.size(); i++) begin
      load_byte(prog_base + 16'(i), prog[i]);
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (3) begin
      check_value(mem_req.address, 16'hFFFC, "address in reset");
      check_value({15'd0, mem_req.wr_enable}, 16'd0, "wr_enable in reset");
      @(negedge clk);
    end
    resetn = 1'b1;
    check_value(mem_req.address, 16'hFFFC, "address after reset");
    check_value({15'd0, mem_req.wr_enable}, 16'd0, "wr_enable after reset");
    repeat (2) @(negedge clk);
    check_value(mem_req.address, prog_base, "first fetch address");
  endtask

  task automatic wait_writes(input int count);
    while (write_count < count) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int    i;
    word_t jmp_addr;
    resetn    = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (i = 0; i < num_rows; i++) begin
      build_alu_program(test_rows[i]);
      run_program(test_rows[i].operand, 8'h00);
      wait_writes(2);
      check_write(0, 16'h0300, test_rows[i].result, $sformatf("row %0d result", i));
      check_write(1, 16'h0301, {7'd0, test_rows[i].carry}, $sformatf("row %0d carry", i));
    end

    build_index_program();
    jmp_addr = prog_base + 16'(prog.size()) - 16'd3;
    run_program(8'h7E, 8'h81);
    wait_writes(4);
    check_write(0, 16'h0300, 8'h5A, "STX of immediate X");
    check_write(1, 16'h0301, 8'hC3, "STY of immediate Y");
    check_write(2, 16'h0302, 8'h7E, "STX of absolute X");
    check_write(3, 16'h0303, 8'h81, "STY of absolute Y");
    // Core sits in the JMP loop and only reads the three JMP bytes
    repeat (20) begin
      @(negedge clk);
      check_value(16'(mem_req.address - jmp_addr < 16'd3), 16'd1, "address in JMP loop");
    end
    check_value(16'(write_count), 16'd4, "write count after final JMP");

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/cpu6502_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_decoder.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/cpu6502_top.sv
verification/tb_memory.sv
verification/tb_cpu6502.sv

//--- Makefile
# Verilator build, run, lint and clean for the reduced 6502 core

TOP := tb_cpu6502

.PHONY: all lint clean

# Build, run, and fail unless the pass line shows up in the output
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

obj_dir/V$(TOP): compile.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f compile.f --top-module cpu6502_top

clean:
	rm -rf obj_dir
